// ==== hdl/comp_dma_pkg.sv ====
package comp_dma_pkg;

    // --------------------
    // bus and data widths
    // --------------------

    // byte address on the AHB bus
    typedef logic [31:0] addr_t;

    // one AHB data beat
    typedef logic [31:0] word_t;

    // one compressor beat, two bus words
    typedef logic [63:0] dword_t;

    // block count or block index
    typedef logic [24:0] blk_cnt_t;

    // beat number inside one burst
    typedef logic [3:0] beat_idx_t;

    // entry address in a compressor result buffer
    typedef logic [2:0] buf_addr_t;

    // --------------------
    // AHB encodings
    // --------------------

    typedef logic [1:0] htrans_t;

    localparam htrans_t htrans_idle   = 2'b00;
    localparam htrans_t htrans_nonseq = 2'b10;
    localparam htrans_t htrans_seq    = 2'b11;

    // --------------------
    // block geometry
    // --------------------

    // INCR16, 32-bit beats
    localparam int burst_len  = 16;
    localparam int beat_bytes = 4;

    // source block is two read bursts, compressed block is one write burst
    localparam int blk_bytes  = 128;
    localparam int cblk_bytes = 64;

endpackage

// ==== hdl/ahb_burst_master.sv ====
`timescale 1ns/1ps

module ahb_burst_master (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    burst_req_i,
    input  comp_dma_pkg::addr_t     burst_addr_i,
    input  logic                    burst_write_i,
    output logic                    burst_done_o,

    output logic                    rd_beat_o,
    output comp_dma_pkg::word_t     rd_data_o,

    output comp_dma_pkg::beat_idx_t wr_idx_o,
    input  comp_dma_pkg::word_t     wr_word_i,

    output logic                    hbusreq_o,
    input  logic                    hgrant_i,
    output comp_dma_pkg::addr_t     haddr_o,
    output comp_dma_pkg::htrans_t   htrans_o,
    output logic                    hwrite_o,
    output comp_dma_pkg::word_t     hwdata_o,
    input  comp_dma_pkg::word_t     hrdata_i,
    input  logic                    hready_i
);

    import comp_dma_pkg::*;

    // address phases run one beat ahead of data phases
    //   addr : | 0 | 1 | 2 | .. |15 |
    //   data :     | 0 | 1 | .. |14 |15 |
    typedef enum logic [2:0] {
        st_idle,
        st_busreq,
        st_first_addr,
        st_middle,
        st_last_data
    } burst_state_e;

    burst_state_e state;

    logic      hbusreq;
    htrans_t   htrans;
    logic      hwrite;
    addr_t     haddr;
    word_t     hwdata;

    // request captured while waiting for the bus
    addr_t     addr_q;
    logic      write_q;

    beat_idx_t addr_cnt;
    beat_idx_t data_cnt;

    logic      grant_take;
    logic      addr_acc;
    logic      data_acc;

    assign grant_take = (state == st_busreq) && hgrant_i;
    assign addr_acc   = ((state == st_first_addr) || (state == st_middle)) && hready_i;
    assign data_acc   = ((state == st_middle) || (state == st_last_data)) && hready_i;

    // --------------------
    // control FSM
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            hbusreq  <= 1'b0;
            htrans   <= htrans_idle;
            hwrite   <= 1'b0;
            addr_cnt <= '0;
            data_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (burst_req_i) begin
                        hbusreq <= 1'b1;
                        state   <= st_busreq;
                    end
                end
                st_busreq: begin
                    if (hgrant_i) begin
                        hbusreq  <= 1'b0;
                        htrans   <= htrans_nonseq;
                        hwrite   <= write_q;
                        addr_cnt <= '0;
                        data_cnt <= '0;
                        state    <= st_first_addr;
                    end
                end
                st_first_addr: begin
                    if (hready_i) begin
                        htrans   <= htrans_seq;
                        addr_cnt <= addr_cnt + 1'b1;
                        state    <= st_middle;
                    end
                end
                st_middle: begin
                    if (hready_i) begin
                        addr_cnt <= addr_cnt + 1'b1;
                        data_cnt <= data_cnt + 1'b1;
                        // last address goes out together with data beat 14
                        if (data_cnt == beat_idx_t'(burst_len - 2)) begin
                            htrans <= htrans_idle;
                            state  <= st_last_data;
                        end
                    end
                end
                st_last_data: begin
                    if (hready_i) begin
                        hwrite <= 1'b0;
                        state  <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // --------------------
    // address and write data
    // --------------------

    always_ff @(posedge clk) begin
        if (burst_req_i) begin
            addr_q  <= burst_addr_i;
            write_q <= burst_write_i;
        end
        if (grant_take) begin
            haddr <= addr_q;
        end else if (addr_acc) begin
            haddr <= haddr + addr_t'(beat_bytes);
        end
        // word for the beat whose address phase just got accepted
        if (addr_acc && hwrite) begin
            hwdata <= wr_word_i;
        end
    end

    assign burst_done_o = (state == st_last_data) && hready_i;
    assign rd_beat_o    = data_acc && !hwrite;
    assign rd_data_o    = hrdata_i;
    assign wr_idx_o     = addr_cnt;

    assign hbusreq_o    = hbusreq;
    assign haddr_o      = haddr;
    assign htrans_o     = htrans;
    assign hwrite_o     = hwrite;
    assign hwdata_o     = hwdata;

    // --------------------
    // checks
    // --------------------

    // the sequencer must wait for the previous burst to finish
    a_req_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        burst_req_i |-> (state == st_idle));

    // nonseq only on the first beat, straight after the grant
    a_nonseq_first: assert property (@(posedge clk) disable iff (!rst_n)
        (htrans_o == htrans_nonseq) |->
            (state == st_first_addr) && ($past(state) inside {st_busreq, st_first_addr}));

endmodule

// ==== hdl/blk_sequencer.sv ====
`timescale 1ns/1ps

module blk_sequencer #(
    parameter int n_comp = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,

    input  comp_dma_pkg::addr_t    src_addr_i,
    input  comp_dma_pkg::addr_t    dst_addr_i,
    input  comp_dma_pkg::blk_cnt_t len_i,
    input  logic                   start_i,
    output logic                   done_o,

    output logic                   burst_req_o,
    output comp_dma_pkg::addr_t    burst_addr_o,
    output logic                   burst_write_o,
    input  logic                   burst_done_i,

    input  logic [n_comp-1:0]      comp_done_i,
    output logic                   owner_load_o
);

    import comp_dma_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_read1,
        st_read2,
        st_compress,
        st_write
    } seq_state_e;

    seq_state_e state;

    // set once the burst of the current state has been requested
    logic     req_issued;
    blk_cnt_t blk_idx;
    blk_cnt_t blk_next;

    // command captured at start
    addr_t    src_q;
    addr_t    dst_q;
    blk_cnt_t len_q;

    logic     all_done;

    assign all_done = &comp_done_i;
    assign blk_next = blk_idx + 1'b1;

    // --------------------
    // block loop
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            req_issued <= 1'b0;
            blk_idx    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start_i && (len_i != '0)) begin
                        blk_idx    <= '0;
                        req_issued <= 1'b0;
                        state      <= st_read1;
                    end
                end
                st_read1: begin
                    if (burst_req_o) begin
                        req_issued <= 1'b1;
                    end else if (burst_done_i) begin
                        req_issued <= 1'b0;
                        state      <= st_read2;
                    end
                end
                st_read2: begin
                    if (burst_req_o) begin
                        req_issued <= 1'b1;
                    end else if (burst_done_i) begin
                        req_issued <= 1'b0;
                        state      <= st_compress;
                    end
                end
                st_compress: begin
                    if (all_done) begin
                        state <= st_write;
                    end
                end
                st_write: begin
                    if (burst_req_o) begin
                        req_issued <= 1'b1;
                    end else if (burst_done_i) begin
                        req_issued <= 1'b0;
                        blk_idx    <= blk_next;
                        if (blk_next == len_q) begin
                            state <= st_idle;
                        end else begin
                            state <= st_read1;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && start_i) begin
            src_q <= src_addr_i;
            dst_q <= dst_addr_i;
            len_q <= len_i;
        end
    end

    // --------------------
    // burst requests
    // --------------------

    always_comb begin
        case (state)
            st_read2: burst_addr_o = src_q + addr_t'(blk_idx) * addr_t'(blk_bytes)
                                     + addr_t'(burst_len * beat_bytes);
            st_write: burst_addr_o = dst_q + addr_t'(blk_idx) * addr_t'(cblk_bytes);
            default:  burst_addr_o = src_q + addr_t'(blk_idx) * addr_t'(blk_bytes);
        endcase
    end

    assign burst_req_o   = (state inside {st_read1, st_read2, st_write}) && !req_issued;
    assign burst_write_o = (state == st_write);
    assign owner_load_o  = (state == st_compress) && all_done;
    assign done_o        = (state == st_idle);

    // a burst completes only after it was requested
    a_done_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        burst_done_i |-> req_issued && (state inside {st_read1, st_read2, st_write}));

endmodule

// ==== hdl/beat_packer.sv ====
`timescale 1ns/1ps

module beat_packer (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 rd_beat_i,
    input  comp_dma_pkg::word_t  rd_data_i,

    output logic                 comp_wren_o,
    output logic                 comp_sop_o,
    output logic                 comp_eop_o,
    output comp_dma_pkg::dword_t comp_wdata_o
);

    import comp_dma_pkg::*;

    // word count within a block, two bursts of 16
    logic [4:0] beat_cnt;
    dword_t     pack_q;
    logic       wren;
    logic       sop;
    logic       eop;
    logic       odd_word;

    assign odd_word = rd_beat_i && beat_cnt[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            wren     <= 1'b0;
            sop      <= 1'b0;
            eop      <= 1'b0;
        end else begin
            if (rd_beat_i) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            // fire once the lower half is in
            wren <= odd_word;
            sop  <= odd_word && (beat_cnt[4:1] == 4'd0);
            eop  <= odd_word && (beat_cnt[4:1] == 4'd15);
        end
    end

    // even word is the upper half
    always_ff @(posedge clk) begin
        if (rd_beat_i && !beat_cnt[0]) begin
            pack_q[63:32] <= rd_data_i;
        end
        if (odd_word) begin
            pack_q[31:0] <= rd_data_i;
        end
    end

    assign comp_wren_o  = wren;
    assign comp_sop_o   = sop;
    assign comp_eop_o   = eop;
    assign comp_wdata_o = pack_q;

endmodule

// ==== hdl/result_select.sv ====
`timescale 1ns/1ps

module result_select #(
    parameter int n_comp = 3
) (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      owner_load_i,
    input  logic [n_comp-1:0]         comp_fail_i,
    input  logic [n_comp*64-1:0]      comp_rdata_i,

    input  comp_dma_pkg::beat_idx_t   wr_idx_i,
    output comp_dma_pkg::buf_addr_t   buf_addr_o,
    output comp_dma_pkg::word_t       wr_word_o
);

    import comp_dma_pkg::*;

    localparam int own_w = (n_comp > 1) ? $clog2(n_comp) : 1;

    logic [own_w-1:0] winner;
    logic [own_w-1:0] owner;
    dword_t           owner_data;

    // lowest passing compressor, 0 when all failed
    always_comb begin
        winner = '0;
        for (int i = n_comp - 1; i >= 0; i--) begin
            if (!comp_fail_i[i]) begin
                winner = own_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner <= '0;
        end else if (owner_load_i) begin
            owner <= winner;
        end
    end

    // --------------------
    // write word mux
    // --------------------

    assign owner_data = comp_rdata_i[owner*64 +: 64];

    // two bus beats per buffer entry
    assign buf_addr_o = wr_idx_i[3:1];

    // even beat takes the upper half
    assign wr_word_o  = wr_idx_i[0] ? owner_data[31:0] : owner_data[63:32];

endmodule

// ==== hdl/comp_dma_engine.sv ====
`timescale 1ns/1ps

module comp_dma_engine #(
    parameter int n_comp = 3
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  comp_dma_pkg::addr_t     src_addr_i,
    input  comp_dma_pkg::addr_t     dst_addr_i,
    input  comp_dma_pkg::blk_cnt_t  len_i,
    input  logic                    start_i,
    output logic                    done_o,

    output logic                    hbusreq_o,
    input  logic                    hgrant_i,
    output comp_dma_pkg::addr_t     haddr_o,
    output comp_dma_pkg::htrans_t   htrans_o,
    output logic                    hwrite_o,
    output comp_dma_pkg::word_t     hwdata_o,
    input  comp_dma_pkg::word_t     hrdata_i,
    input  logic                    hready_i,

    output logic                    comp_wren_o,
    output logic                    comp_sop_o,
    output logic                    comp_eop_o,
    output comp_dma_pkg::dword_t    comp_wdata_o,
    input  logic [n_comp-1:0]       comp_done_i,
    input  logic [n_comp-1:0]       comp_fail_i,
    output comp_dma_pkg::buf_addr_t buf_addr_o,
    input  logic [n_comp*64-1:0]    comp_rdata_i
);

    import comp_dma_pkg::*;

    // sequencer to master
    logic      burst_req;
    addr_t     burst_addr;
    logic      burst_write;
    logic      burst_done;

    // read and write data paths
    logic      rd_beat;
    word_t     rd_data;
    beat_idx_t wr_idx;
    word_t     wr_word;

    logic      owner_load;

    blk_sequencer #(
        .n_comp (n_comp)
    ) blk_sequencer_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .src_addr_i    (src_addr_i),
        .dst_addr_i    (dst_addr_i),
        .len_i         (len_i),
        .start_i       (start_i),
        .done_o        (done_o),
        .burst_req_o   (burst_req),
        .burst_addr_o  (burst_addr),
        .burst_write_o (burst_write),
        .burst_done_i  (burst_done),
        .comp_done_i   (comp_done_i),
        .owner_load_o  (owner_load)
    );

    ahb_burst_master ahb_burst_master_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .burst_req_i   (burst_req),
        .burst_addr_i  (burst_addr),
        .burst_write_i (burst_write),
        .burst_done_o  (burst_done),
        .rd_beat_o     (rd_beat),
        .rd_data_o     (rd_data),
        .wr_idx_o      (wr_idx),
        .wr_word_i     (wr_word),
        .hbusreq_o     (hbusreq_o),
        .hgrant_i      (hgrant_i),
        .haddr_o       (haddr_o),
        .htrans_o      (htrans_o),
        .hwrite_o      (hwrite_o),
        .hwdata_o      (hwdata_o),
        .hrdata_i      (hrdata_i),
        .hready_i      (hready_i)
    );

    beat_packer beat_packer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_beat_i    (rd_beat),
        .rd_data_i    (rd_data),
        .comp_wren_o  (comp_wren_o),
        .comp_sop_o   (comp_sop_o),
        .comp_eop_o   (comp_eop_o),
        .comp_wdata_o (comp_wdata_o)
    );

    result_select #(
        .n_comp (n_comp)
    ) result_select_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .owner_load_i (owner_load),
        .comp_fail_i  (comp_fail_i),
        .comp_rdata_i (comp_rdata_i),
        .wr_idx_i     (wr_idx),
        .buf_addr_o   (buf_addr_o),
        .wr_word_o    (wr_word)
    );

endmodule

// ==== verification/tb_comp_dma_engine.sv ====
`timescale 1ns/1ps

module tb_comp_dma_engine;

    import comp_dma_pkg::*;

    localparam int n_comp  = 3;
    localparam int n_multi = 6;
    // per block: three bursts with grant waits and hready stalls, plus compress wait
    localparam int blk_cycle_bound = 400;
    localparam int watchdog_cycles = (1 + n_multi) * blk_cycle_bound + 200;

    logic                    clk;
    logic                    rst_n;
    addr_t                   src_addr_i;
    addr_t                   dst_addr_i;
    blk_cnt_t                len_i;
    logic                    start_i;
    logic                    done_o;
    logic                    hbusreq_o;
    logic                    hgrant_i;
    addr_t                   haddr_o;
    htrans_t                 htrans_o;
    logic                    hwrite_o;
    word_t                   hwdata_o;
    word_t                   hrdata_i;
    logic                    hready_i;
    logic                    comp_wren_o;
    logic                    comp_sop_o;
    logic                    comp_eop_o;
    dword_t                  comp_wdata_o;
    logic [n_comp-1:0]       comp_done_i;
    logic [n_comp-1:0]       comp_fail_i;
    buf_addr_t               buf_addr_o;
    logic [n_comp*64-1:0]    comp_rdata_i;

    // AHB slave memory, 16 KB
    word_t       mem [0:4095];
    // compressor result buffers
    dword_t      cbuf [0:n_comp-1][0:15];
    logic [n_comp-1:0] fail_pat [0:15];

    logic [31:0] lfsr_q;
    logic        stall_en;
    int          err_cnt;
    int          burst_errs;
    int          failed_tests;
    int          errs_before;

    // slave pipeline and stall tracking
    logic        dp_valid;
    logic        dp_write;
    addr_t       dp_addr;
    logic        prev_ready;
    addr_t       last_haddr;
    htrans_t     last_htrans;
    word_t       last_hwdata;
    int          gnt_wait;

    // burst and packing monitors
    addr_t       cur_src;
    addr_t       cur_dst;
    addr_t       exp_addr;
    addr_t       next_addr;
    logic        burst_write;
    int          beat_in_burst;
    int          bursts_run;
    int          bursts_total;
    int          burst_blk;
    int          burst_pos;
    int          wren_cnt;
    int          beat_pos;
    int          pair_k;
    int          pair_blk;
    int          done_wait [0:n_comp-1];
    logic [n_comp-1:0] done_pend;

    comp_dma_engine #(
        .n_comp (n_comp)
    ) comp_dma_engine_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .src_addr_i   (src_addr_i),
        .dst_addr_i   (dst_addr_i),
        .len_i        (len_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .hbusreq_o    (hbusreq_o),
        .hgrant_i     (hgrant_i),
        .haddr_o      (haddr_o),
        .htrans_o     (htrans_o),
        .hwrite_o     (hwrite_o),
        .hwdata_o     (hwdata_o),
        .hrdata_i     (hrdata_i),
        .hready_i     (hready_i),
        .comp_wren_o  (comp_wren_o),
        .comp_sop_o   (comp_sop_o),
        .comp_eop_o   (comp_eop_o),
        .comp_wdata_o (comp_wdata_o),
        .comp_done_i  (comp_done_i),
        .comp_fail_i  (comp_fail_i),
        .buf_addr_o   (buf_addr_o),
        .comp_rdata_i (comp_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // helpers
    // --------------------

    // galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic next_rand_bit();
        logic lsb;
        lsb    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (lsb) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_rand_bit()};
        end
        return r;
    endfunction

    function automatic dword_t comp_tag(input int c);
        return 64'h5a5a_0f0f_f0f0_a5a5 + 64'(c + 1) * 64'h0101_0101_0101_0101;
    endfunction

    // pair k of a block: even word upper, odd word lower
    function automatic dword_t packed_beat(input addr_t src, input int blk, input int k);
        addr_t a;
        a = src + addr_t'(blk * 128 + k * 8);
        return {mem[a[13:2]], mem[a[13:2] + 12'd1]};
    endfunction

    // first compressor with a clear fail bit, else 0
    function automatic int owner_of(input logic [n_comp-1:0] fail);
        int  own;
        logic found;
        own   = 0;
        found = 1'b0;
        for (int c = 0; c < n_comp; c++) begin
            if (!found && !fail[c]) begin
                own   = c;
                found = 1'b1;
            end
        end
        return own;
    endfunction

    function automatic word_t expected_dst_word(input addr_t src, input int blk, input int w,
                                                input logic [n_comp-1:0] fail);
        dword_t entry;
        entry = packed_beat(src, blk, w / 2) ^ comp_tag(owner_of(fail));
        return (w % 2 == 0) ? entry[63:32] : entry[31:0];
    endfunction

    task automatic report_fail(input string msg);
        $display("Fail %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic burst_fail(input string msg);
        report_fail(msg);
        burst_errs++;
    endtask

    task automatic end_test(input int num, input string name, input int errs);
        if (errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errs);
            failed_tests++;
        end
    endtask

    task automatic run_dma(input addr_t src, input addr_t dst, input blk_cnt_t len);
        @(negedge clk);
        cur_src    = src;
        cur_dst    = dst;
        wren_cnt   = 0;
        bursts_run = 0;
        src_addr_i = src;
        dst_addr_i = dst;
        len_i      = len;
        start_i    = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        if (len != 0) begin
            assert (!done_o) else report_fail("done_o did not fall after start");
            while (!done_o) begin
                @(negedge clk);
            end
            assert (wren_cnt == 16 * int'(len))
                else report_fail($sformatf("%0d comp_wren_o pulses, expected %0d",
                                           wren_cnt, 16 * int'(len)));
            assert (bursts_run == 3 * int'(len))
                else report_fail($sformatf("%0d bursts, expected %0d",
                                           bursts_run, 3 * int'(len)));
            assert (beat_in_burst == 0) else report_fail("last burst ended early");
        end
    endtask

    task automatic check_dest(input addr_t src, input addr_t dst, input int len);
        addr_t a;
        word_t exp;
        for (int b = 0; b < len; b++) begin
            for (int w = 0; w < 16; w++) begin
                a   = dst + addr_t'(b * 64 + w * 4);
                exp = expected_dst_word(src, b, w, fail_pat[b]);
                assert (mem[a[13:2]] == exp)
                    else report_fail($sformatf("dst %h holds %h, expected %h",
                                               a, mem[a[13:2]], exp));
            end
        end
    endtask

    // --------------------
    // bus and compressor models
    // --------------------

    always @(negedge clk) begin
        // address, transfer type and write data hold across a stall
        if (!prev_ready && last_htrans != htrans_idle) begin
            assert (haddr_o == last_haddr && htrans_o == last_htrans)
                else burst_fail("address phase changed during hready stall");
        end
        if (!prev_ready && dp_valid && dp_write) begin
            assert (hwdata_o == last_hwdata)
                else burst_fail("hwdata changed during hready stall");
        end

        // compressors see the same beats
        if (comp_wren_o) begin
            pair_k   = wren_cnt % 16;
            pair_blk = wren_cnt / 16;
            assert (comp_wdata_o == packed_beat(cur_src, pair_blk, pair_k))
                else report_fail($sformatf("comp_wdata_o %h, expected %h", comp_wdata_o,
                                           packed_beat(cur_src, pair_blk, pair_k)));
            assert (comp_sop_o == (pair_k == 0))
                else report_fail($sformatf("comp_sop_o wrong on pair %0d", pair_k));
            assert (comp_eop_o == (pair_k == 15))
                else report_fail($sformatf("comp_eop_o wrong on pair %0d", pair_k));
            if (comp_sop_o) begin
                beat_pos    = 0;
                comp_done_i = '0;
            end
            for (int c = 0; c < n_comp; c++) begin
                cbuf[c][beat_pos] = comp_wdata_o ^ comp_tag(c);
            end
            beat_pos = (beat_pos + 1) % 16;
            if (comp_eop_o) begin
                comp_fail_i = fail_pat[pair_blk];
                for (int c = 0; c < n_comp; c++) begin
                    done_wait[c] = rand_bits(3);
                end
                done_pend = '1;
            end
            wren_cnt++;
        end else begin
            assert (!comp_sop_o && !comp_eop_o)
                else report_fail("sop or eop without comp_wren_o");
        end
        for (int c = 0; c < n_comp; c++) begin
            if (done_pend[c]) begin
                if (done_wait[c] == 0) begin
                    comp_done_i[c] = 1'b1;
                    done_pend[c]   = 1'b0;
                end else begin
                    done_wait[c]--;
                end
            end
            comp_rdata_i[c*64 +: 64] = cbuf[c][buf_addr_o];
        end

        // hready and grant for the coming edge
        hready_i = stall_en ? (rand_bits(2) != 2'b00) : 1'b1;
        if (!hbusreq_o) begin
            hgrant_i = 1'b0;
            gnt_wait = stall_en ? int'(rand_bits(2)) : 0;
        end else if (gnt_wait == 0) begin
            hgrant_i = 1'b1;
        end else begin
            gnt_wait--;
        end

        // burst format
        if (hready_i && htrans_o == htrans_nonseq) begin
            burst_blk = bursts_run / 3;
            burst_pos = bursts_run % 3;
            if (burst_pos == 2) begin
                exp_addr = cur_dst + addr_t'(burst_blk * cblk_bytes);
            end else begin
                exp_addr = cur_src + addr_t'(burst_blk * blk_bytes + burst_pos * 64);
            end
            assert (beat_in_burst == 0) else burst_fail("nonseq inside a running burst");
            assert (haddr_o == exp_addr)
                else burst_fail($sformatf("burst starts at %h, expected %h", haddr_o, exp_addr));
            assert (hwrite_o == (burst_pos == 2))
                else burst_fail($sformatf("hwrite_o %b on burst %0d", hwrite_o, bursts_run));
            burst_write   = hwrite_o;
            next_addr     = haddr_o + 32'd4;
            beat_in_burst = 1;
            bursts_run++;
            bursts_total++;
        end else if (hready_i && htrans_o == htrans_seq) begin
            assert (beat_in_burst != 0) else burst_fail("seq outside a burst");
            assert (haddr_o == next_addr)
                else burst_fail($sformatf("seq address %h, expected %h", haddr_o, next_addr));
            assert (hwrite_o == burst_write) else burst_fail("hwrite_o changed inside burst");
            next_addr     = next_addr + 32'd4;
            beat_in_burst = (beat_in_burst == 15) ? 0 : beat_in_burst + 1;
        end

        // slave data phase, then take the new address phase
        if (dp_valid && !dp_write) begin
            hrdata_i = mem[dp_addr[13:2]];
        end
        if (hready_i) begin
            if (dp_valid && dp_write) begin
                mem[dp_addr[13:2]] = hwdata_o;
            end
            dp_valid = (htrans_o == htrans_nonseq) || (htrans_o == htrans_seq);
            dp_write = hwrite_o;
            dp_addr  = haddr_o;
        end

        prev_ready  = hready_i;
        last_haddr  = haddr_o;
        last_htrans = htrans_o;
        last_hwdata = hwdata_o;
    end

    // --------------------
    // watchdog
    // --------------------

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Some tests failed");
        $finish;
    end

    // --------------------
    // stimulus
    // --------------------

    initial begin
        lfsr_q        = 32'h790d;
        rst_n         = 1'b0;
        src_addr_i    = '0;
        dst_addr_i    = '0;
        len_i         = '0;
        start_i       = 1'b0;
        hgrant_i      = 1'b0;
        hrdata_i      = '0;
        hready_i      = 1'b1;
        comp_done_i   = '0;
        comp_fail_i   = '0;
        comp_rdata_i  = '0;
        stall_en      = 1'b0;
        err_cnt       = 0;
        burst_errs    = 0;
        failed_tests  = 0;
        dp_valid      = 1'b0;
        dp_write      = 1'b0;
        dp_addr       = '0;
        prev_ready    = 1'b1;
        gnt_wait      = 0;
        beat_in_burst = 0;
        bursts_run    = 0;
        bursts_total  = 0;
        wren_cnt      = 0;
        beat_pos      = 0;
        done_pend     = '0;
        cur_src       = '0;
        cur_dst       = '0;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = rand_bits(32) ^ (32'(i) * 32'h9e37_79b9);
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errs_before = err_cnt;
        assert (done_o && !hbusreq_o && htrans_o == htrans_idle && !comp_wren_o)
            else report_fail("outputs not inactive after reset");
        end_test(1, "reset state", err_cnt - errs_before);

        // zero length start
        errs_before = err_cnt;
        run_dma(32'h0000_0100, 32'h0000_2000, '0);
        repeat (20) begin
            @(negedge clk);
            assert (done_o && !hbusreq_o)
                else report_fail("bus request or busy after a zero length start");
        end
        end_test(2, "zero length", err_cnt - errs_before);

        // one block, no stalls, compressor 0 passes
        errs_before = err_cnt;
        fail_pat[0] = 3'b010;
        run_dma(32'h0000_0100, 32'h0000_2000, 25'd1);
        check_dest(32'h0000_0100, 32'h0000_2000, 1);
        end_test(3, "single block", err_cnt - errs_before);

        // several blocks with stalls, grant delays and fail patterns
        errs_before = err_cnt;
        stall_en    = 1'b1;
        fail_pat[0] = 3'b001;
        fail_pat[1] = 3'b111;
        fail_pat[2] = 3'b011;
        for (int b = 3; b < n_multi; b++) begin
            fail_pat[b] = rand_bits(n_comp);
        end
        run_dma(32'h0000_0800, 32'h0000_3000, 25'(n_multi));
        check_dest(32'h0000_0800, 32'h0000_3000, n_multi);
        // engine stays idle once the last block is written
        repeat (4) begin
            @(negedge clk);
            assert (done_o && !hbusreq_o)
                else report_fail("engine busy again after the last block");
        end
        end_test(4, "multi block", err_cnt - errs_before);

        assert (bursts_total == 3 * (1 + n_multi))
            else burst_fail($sformatf("%0d bursts seen in total", bursts_total));
        end_test(5, "burst format", burst_errs);

        $display("tests run: 5, failing tests: %0d, errors: %0d", failed_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/comp_dma_pkg.sv
hdl/ahb_burst_master.sv
hdl/blk_sequencer.sv
hdl/beat_packer.sv
hdl/result_select.sv
hdl/comp_dma_engine.sv
verification/tb_comp_dma_engine.sv

// ==== Bender.yml ====
package:
  name: comp_dma_engine

sources:
  - hdl/comp_dma_pkg.sv
  - hdl/ahb_burst_master.sv
  - hdl/blk_sequencer.sv
  - hdl/beat_packer.sv
  - hdl/result_select.sv
  - hdl/comp_dma_engine.sv
  - target: simulation
    files:
      - verification/tb_comp_dma_engine.sv
